// File: logic/exu_pkg.sv
`default_nettype none

package exu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int CSR_ADDR_W = 32; // carried full width

    //////////////////////////////
    // opcodes
    //////////////////////////////
    localparam logic [6:0] OPC_TYPE_I = 7'b0010011;
    localparam logic [6:0] OPC_TYPE_R = 7'b0110011;
    localparam logic [6:0] OPC_TYPE_L = 7'b0000011;
    localparam logic [6:0] OPC_TYPE_S = 7'b0100011;
    localparam logic [6:0] OPC_TYPE_B = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_CSR    = 7'b1110011;
    localparam logic [6:0] OPC_NOP    = 7'b0000001;

    //////////////////////////////
    // funct3
    //////////////////////////////
    // alu, same for register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    typedef enum logic [3:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_BRANCH,
        CLS_JUMP,   // jal, jalr
        CLS_UPPER,  // lui, auipc
        CLS_FENCE,
        CLS_LOAD,
        CLS_STORE,
        CLS_CSR
    } op_class_e;

endpackage

`default_nettype wire

// File: logic/exu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module exu_decode (
    input  wire logic [exu_pkg::XLEN-1:0] inst_i,
    output exu_pkg::op_class_e            op_class_o,
    output logic [2:0]                    funct3_o,
    output logic                          alt_o,
    output logic [4:0]                    zimm_o
);

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic       r_valid;

    assign opcode   = inst_i[6:0];
    assign funct7   = inst_i[31:25];
    assign funct3_o = inst_i[14:12];
    assign zimm_o   = inst_i[19:15];

    // funct7 of one (mul/div) is not supported
    assign r_valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);

    always_comb begin
        case (opcode)
            exu_pkg::OPC_TYPE_I:                 op_class_o = exu_pkg::CLS_ALU;
            exu_pkg::OPC_TYPE_R:                 op_class_o = r_valid ? exu_pkg::CLS_ALU
                                                                      : exu_pkg::CLS_NONE;
            exu_pkg::OPC_TYPE_B:                 op_class_o = exu_pkg::CLS_BRANCH;
            exu_pkg::OPC_JAL, exu_pkg::OPC_JALR: op_class_o = exu_pkg::CLS_JUMP;
            exu_pkg::OPC_LUI, exu_pkg::OPC_AUIPC: op_class_o = exu_pkg::CLS_UPPER;
            exu_pkg::OPC_FENCE:                  op_class_o = exu_pkg::CLS_FENCE;
            exu_pkg::OPC_TYPE_L:                 op_class_o = exu_pkg::CLS_LOAD;
            exu_pkg::OPC_TYPE_S:                 op_class_o = exu_pkg::CLS_STORE;
            exu_pkg::OPC_CSR:                    op_class_o = exu_pkg::CLS_CSR;
            default:                             op_class_o = exu_pkg::CLS_NONE;
        endcase
    end

    // bit 30 selects sub and arithmetic shift
    always_comb begin
        alt_o = 1'b0;
        if (opcode == exu_pkg::OPC_TYPE_R) begin
            alt_o = inst_i[30] && (funct3_o == exu_pkg::F3_ADD_SUB ||
                                   funct3_o == exu_pkg::F3_SR);
        end else if (opcode == exu_pkg::OPC_TYPE_I) begin
            alt_o = inst_i[30] && (funct3_o == exu_pkg::F3_SR); // addi has no sub form
        end
    end

endmodule

`default_nettype wire

// File: logic/exu_alu.sv
`timescale 1ns/1ns
`default_nettype none

module exu_alu (
    input  wire exu_pkg::op_class_e       op_class_i,
    input  wire logic [2:0]               funct3_i,
    input  wire logic                     alt_i,
    input  wire logic [exu_pkg::XLEN-1:0] op1_i,
    input  wire logic [exu_pkg::XLEN-1:0] op2_i,
    output logic [exu_pkg::XLEN-1:0]      result_o
);

    logic [exu_pkg::XLEN-1:0] sum;
    logic [4:0]               shamt;
    logic                     lt_s;
    logic                     lt_u;

    assign sum   = op1_i + op2_i;
    assign shamt = op2_i[4:0];
    assign lt_s  = $signed(op1_i) < $signed(op2_i);
    assign lt_u  = op1_i < op2_i;

    //////////////////////////////
    // result select
    //////////////////////////////
    always_comb begin
        result_o = '0;
        case (op_class_i)
            exu_pkg::CLS_ALU: begin
                case (funct3_i)
                    exu_pkg::F3_ADD_SUB: result_o = alt_i ? (op1_i - op2_i) : sum;
                    exu_pkg::F3_SLL:     result_o = op1_i << shamt;
                    exu_pkg::F3_SLT:     result_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_s};
                    exu_pkg::F3_SLTU:    result_o = {{(exu_pkg::XLEN-1){1'b0}}, lt_u};
                    exu_pkg::F3_XOR:     result_o = op1_i ^ op2_i;
                    exu_pkg::F3_SR: begin
                        if (alt_i) begin
                            result_o = $unsigned($signed(op1_i) >>> shamt);
                        end else begin
                            result_o = op1_i >> shamt;
                        end
                    end
                    exu_pkg::F3_OR:      result_o = op1_i | op2_i;
                    exu_pkg::F3_AND:     result_o = op1_i & op2_i;
                    default:             result_o = '0;
                endcase
            end
            // link value pc+4, or upper immediate
            exu_pkg::CLS_UPPER, exu_pkg::CLS_JUMP: result_o = sum;
            default: result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/exu_branch.sv
`timescale 1ns/1ns
`default_nettype none

module exu_branch (
    input  wire exu_pkg::op_class_e       op_class_i,
    input  wire logic [2:0]               funct3_i,
    input  wire logic [exu_pkg::XLEN-1:0] op1_i,
    input  wire logic [exu_pkg::XLEN-1:0] op2_i,
    input  wire logic [exu_pkg::XLEN-1:0] op1_jump_i,
    input  wire logic [exu_pkg::XLEN-1:0] op2_jump_i,
    output logic                          jump_o,
    output logic [exu_pkg::XLEN-1:0]      jump_addr_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic taken;

    assign eq   = op1_i == op2_i;
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (funct3_i)
            exu_pkg::F3_BEQ:  taken = eq;
            exu_pkg::F3_BNE:  taken = !eq;
            exu_pkg::F3_BLT:  taken = lt_s;
            exu_pkg::F3_BGE:  taken = !lt_s;
            exu_pkg::F3_BLTU: taken = lt_u;
            exu_pkg::F3_BGEU: taken = !lt_u;
            default:          taken = 1'b0;
        endcase
    end

    // fence redirects to pc+4
    assign jump_o = (op_class_i == exu_pkg::CLS_BRANCH && taken) ||
                    (op_class_i == exu_pkg::CLS_JUMP) ||
                    (op_class_i == exu_pkg::CLS_FENCE);

    assign jump_addr_o = jump_o ? (op1_jump_i + op2_jump_i) : '0;

endmodule

`default_nettype wire

// File: logic/exu_lsu.sv
`timescale 1ns/1ns
`default_nettype none

module exu_lsu (
    input  wire exu_pkg::op_class_e       op_class_i,
    input  wire logic [2:0]               funct3_i,
    input  wire logic [exu_pkg::XLEN-1:0] op1_i,
    input  wire logic [exu_pkg::XLEN-1:0] op2_i,
    input  wire logic [exu_pkg::XLEN-1:0] reg2_r_data_i,
    input  wire logic [exu_pkg::XLEN-1:0] mem_r_data_i,
    output logic [exu_pkg::XLEN-1:0]      mem_addr_o,
    output logic [exu_pkg::XLEN-1:0]      mem_w_data_o,
    output logic [exu_pkg::XLEN-1:0]      load_data_o,
    output logic                          mem_req_o,
    output logic                          mem_we_o
);

    localparam int XLEN = exu_pkg::XLEN;

    logic [XLEN-1:0] addr;
    logic [1:0]      lane;
    logic [4:0]      byte_sh;
    logic [4:0]      half_sh;
    logic [7:0]      rd_byte;
    logic [15:0]     rd_half;
    logic            is_load;
    logic            is_store;

    assign addr     = op1_i + op2_i;
    assign lane     = addr[1:0];
    assign byte_sh  = {lane, 3'b000};
    assign half_sh  = (lane == 2'b00) ? 5'd0 : 5'd16; // lower half only at lane 0
    assign rd_byte  = mem_r_data_i[byte_sh +: 8];
    assign rd_half  = mem_r_data_i[half_sh +: 16];
    assign is_load  = op_class_i == exu_pkg::CLS_LOAD;
    assign is_store = op_class_i == exu_pkg::CLS_STORE;

    assign mem_req_o  = is_load || is_store;
    assign mem_we_o   = is_store;
    assign mem_addr_o = mem_req_o ? addr : '0;

    //////////////////////////////
    // load extraction
    //////////////////////////////
    always_comb begin
        load_data_o = '0;
        if (is_load) begin
            case (funct3_i)
                exu_pkg::F3_LB:  load_data_o = {{(XLEN-8){rd_byte[7]}}, rd_byte};
                exu_pkg::F3_LH:  load_data_o = {{(XLEN-16){rd_half[15]}}, rd_half};
                exu_pkg::F3_LW:  load_data_o = mem_r_data_i;
                exu_pkg::F3_LBU: load_data_o = {{(XLEN-8){1'b0}}, rd_byte};
                exu_pkg::F3_LHU: load_data_o = {{(XLEN-16){1'b0}}, rd_half};
                default:         load_data_o = '0;
            endcase
        end
    end

    //////////////////////////////
    // store merge into read word
    //////////////////////////////
    always_comb begin
        mem_w_data_o = '0;
        if (is_store) begin
            case (funct3_i)
                exu_pkg::F3_SB: begin
                    mem_w_data_o = (mem_r_data_i & ~({{(XLEN-8){1'b0}}, 8'hff} << byte_sh))
                                 | ({{(XLEN-8){1'b0}}, reg2_r_data_i[7:0]} << byte_sh);
                end
                exu_pkg::F3_SH: begin
                    mem_w_data_o = (mem_r_data_i & ~({{(XLEN-16){1'b0}}, 16'hffff} << half_sh))
                                 | ({{(XLEN-16){1'b0}}, reg2_r_data_i[15:0]} << half_sh);
                end
                exu_pkg::F3_SW: mem_w_data_o = reg2_r_data_i;
                default:        mem_w_data_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/exu_csr.sv
`timescale 1ns/1ns
`default_nettype none

module exu_csr (
    input  wire exu_pkg::op_class_e       op_class_i,
    input  wire logic [2:0]               funct3_i,
    input  wire logic [4:0]               zimm_i,
    input  wire logic [exu_pkg::XLEN-1:0] reg1_r_data_i,
    input  wire logic [exu_pkg::XLEN-1:0] csr_r_data_i,
    output logic [exu_pkg::XLEN-1:0]      csr_w_data_o,
    output logic [exu_pkg::XLEN-1:0]      csr_result_o
);

    logic [exu_pkg::XLEN-1:0] src;

    // funct3[2] picks the immediate forms
    assign src = funct3_i[2] ? {{(exu_pkg::XLEN-5){1'b0}}, zimm_i} : reg1_r_data_i;

    always_comb begin
        csr_w_data_o = '0;
        csr_result_o = '0;
        if (op_class_i == exu_pkg::CLS_CSR) begin
            csr_result_o = csr_r_data_i; // old value to rd
            case (funct3_i)
                exu_pkg::F3_CSRRW, exu_pkg::F3_CSRRWI: csr_w_data_o = src;
                exu_pkg::F3_CSRRS, exu_pkg::F3_CSRRSI: csr_w_data_o = csr_r_data_i | src;
                exu_pkg::F3_CSRRC, exu_pkg::F3_CSRRCI: csr_w_data_o = csr_r_data_i & ~src;
                default: csr_result_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/exu_retire.sv
`timescale 1ns/1ns
`default_nettype none

module exu_retire (
    input  wire logic                           clk_i,
    input  wire logic                           arst_n_i,
    input  wire logic [exu_pkg::XLEN-1:0]       alu_result_i,
    input  wire logic [exu_pkg::XLEN-1:0]       load_data_i,
    input  wire logic [exu_pkg::XLEN-1:0]       csr_result_i,
    input  wire logic [exu_pkg::XLEN-1:0]       csr_w_data_i,
    input  wire logic [exu_pkg::XLEN-1:0]       jump_addr_i,
    input  wire logic                           jump_i,
    input  wire logic                           unit_mem_req_i,
    input  wire logic                           unit_mem_we_i,
    input  wire logic                           reg_we_i,
    input  wire logic                           csr_we_i,
    input  wire logic                           int_assert_i,
    input  wire logic [exu_pkg::XLEN-1:0]       int_addr_i,
    input  wire logic [exu_pkg::REG_ADDR_W-1:0] reg_w_addr_i,
    input  wire logic [exu_pkg::CSR_ADDR_W-1:0] csr_w_addr_i,
    output logic                                mem_req_o,
    output logic                                mem_we_o,
    output logic [exu_pkg::XLEN-1:0]            reg_w_data_o,
    output logic                                reg_we_o,
    output logic [exu_pkg::REG_ADDR_W-1:0]      reg_w_addr_o,
    output logic [exu_pkg::XLEN-1:0]            csr_w_data_o,
    output logic                                csr_we_o,
    output logic [exu_pkg::CSR_ADDR_W-1:0]      csr_w_addr_o,
    output logic                                jump_flag_o,
    output logic [exu_pkg::XLEN-1:0]            jump_addr_o
);

    logic [exu_pkg::XLEN-1:0] wb_data;

    assign wb_data = alu_result_i | load_data_i | csr_result_i; // idle units give zero

    // no memory access while taking an interrupt
    assign mem_req_o = unit_mem_req_i && !int_assert_i;
    assign mem_we_o  = unit_mem_we_i && !int_assert_i;

    //////////////////////////////
    // stage register
    //////////////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reg_w_data_o <= '0;
            reg_we_o     <= 1'b0;
            reg_w_addr_o <= '0;
            csr_w_data_o <= '0;
            csr_we_o     <= 1'b0;
            csr_w_addr_o <= '0;
            jump_flag_o  <= 1'b0;
            jump_addr_o  <= '0;
        end else begin
            reg_w_data_o <= wb_data;
            reg_we_o     <= reg_we_i && !int_assert_i;
            reg_w_addr_o <= reg_w_addr_i;
            csr_w_data_o <= csr_w_data_i;
            csr_we_o     <= csr_we_i && !int_assert_i;
            csr_w_addr_o <= csr_w_addr_i;
            jump_flag_o  <= jump_i || int_assert_i;
            jump_addr_o  <= int_assert_i ? int_addr_i : jump_addr_i; // trap vector wins
        end
    end

endmodule

`default_nettype wire

// File: logic/exu_top.sv
`timescale 1ns/1ns
`default_nettype none

module exu_top (
    input  wire logic                           clk_i,
    input  wire logic                           arst_n_i,
    input  wire logic [exu_pkg::XLEN-1:0]       inst_i,
    input  wire logic [exu_pkg::XLEN-1:0]       op1_i,
    input  wire logic [exu_pkg::XLEN-1:0]       op2_i,
    input  wire logic [exu_pkg::XLEN-1:0]       op1_jump_i,
    input  wire logic [exu_pkg::XLEN-1:0]       op2_jump_i,
    input  wire logic [exu_pkg::XLEN-1:0]       reg1_r_data_i,
    input  wire logic [exu_pkg::XLEN-1:0]       reg2_r_data_i,
    input  wire logic                           reg_we_i,
    input  wire logic [exu_pkg::REG_ADDR_W-1:0] reg_w_addr_i,
    input  wire logic                           csr_we_i,
    input  wire logic [exu_pkg::CSR_ADDR_W-1:0] csr_w_addr_i,
    input  wire logic [exu_pkg::XLEN-1:0]       csr_r_data_i,
    input  wire logic [exu_pkg::XLEN-1:0]       mem_r_data_i,
    input  wire logic                           int_assert_i,
    input  wire logic [exu_pkg::XLEN-1:0]       int_addr_i,
    output logic [exu_pkg::XLEN-1:0]            mem_addr_o,
    output logic [exu_pkg::XLEN-1:0]            mem_w_data_o,
    output logic                                mem_we_o,
    output logic                                mem_req_o,
    output logic [exu_pkg::XLEN-1:0]            reg_w_data_o,
    output logic                                reg_we_o,
    output logic [exu_pkg::REG_ADDR_W-1:0]      reg_w_addr_o,
    output logic [exu_pkg::XLEN-1:0]            csr_w_data_o,
    output logic                                csr_we_o,
    output logic [exu_pkg::CSR_ADDR_W-1:0]      csr_w_addr_o,
    output logic                                jump_flag_o,
    output logic [exu_pkg::XLEN-1:0]            jump_addr_o
);

    exu_pkg::op_class_e       op_class;
    logic [2:0]               funct3;
    logic                     alt;
    logic [4:0]               zimm;
    logic [exu_pkg::XLEN-1:0] alu_result;
    logic [exu_pkg::XLEN-1:0] load_data;
    logic [exu_pkg::XLEN-1:0] csr_result;
    logic [exu_pkg::XLEN-1:0] csr_w_data;
    logic [exu_pkg::XLEN-1:0] jump_addr;
    logic                     jump;
    logic                     unit_mem_req;
    logic                     unit_mem_we;

    exu_decode u_decode (
        .inst_i(inst_i), .op_class_o(op_class), .funct3_o(funct3), .alt_o(alt), .zimm_o(zimm)
    );

    exu_alu u_alu (
        .op_class_i(op_class), .funct3_i(funct3), .alt_i(alt),
        .op1_i(op1_i), .op2_i(op2_i), .result_o(alu_result)
    );

    exu_branch u_branch (
        .op_class_i(op_class), .funct3_i(funct3), .op1_i(op1_i), .op2_i(op2_i),
        .op1_jump_i(op1_jump_i), .op2_jump_i(op2_jump_i),
        .jump_o(jump), .jump_addr_o(jump_addr)
    );

    // memory side stays combinational
    exu_lsu u_lsu (
        .op_class_i(op_class), .funct3_i(funct3), .op1_i(op1_i), .op2_i(op2_i),
        .reg2_r_data_i(reg2_r_data_i), .mem_r_data_i(mem_r_data_i),
        .mem_addr_o(mem_addr_o), .mem_w_data_o(mem_w_data_o), .load_data_o(load_data),
        .mem_req_o(unit_mem_req), .mem_we_o(unit_mem_we)
    );

    exu_csr u_csr (
        .op_class_i(op_class), .funct3_i(funct3), .zimm_i(zimm),
        .reg1_r_data_i(reg1_r_data_i), .csr_r_data_i(csr_r_data_i),
        .csr_w_data_o(csr_w_data), .csr_result_o(csr_result)
    );

    exu_retire u_retire (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .alu_result_i(alu_result), .load_data_i(load_data), .csr_result_i(csr_result),
        .csr_w_data_i(csr_w_data), .jump_addr_i(jump_addr), .jump_i(jump),
        .unit_mem_req_i(unit_mem_req), .unit_mem_we_i(unit_mem_we),
        .reg_we_i(reg_we_i), .csr_we_i(csr_we_i),
        .int_assert_i(int_assert_i), .int_addr_i(int_addr_i),
        .reg_w_addr_i(reg_w_addr_i), .csr_w_addr_i(csr_w_addr_i),
        .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
        .reg_w_data_o(reg_w_data_o), .reg_we_o(reg_we_o), .reg_w_addr_o(reg_w_addr_o),
        .csr_w_data_o(csr_w_data_o), .csr_we_o(csr_we_o), .csr_w_addr_o(csr_w_addr_o),
        .jump_flag_o(jump_flag_o), .jump_addr_o(jump_addr_o)
    );

endmodule

`default_nettype wire

// File: sim/exu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module exu_checker (
    input wire logic                     clk_i,
    input wire logic                     arst_n_i,
    input wire logic                     mem_req_o,
    input wire logic                     mem_we_o,
    input wire logic                     int_assert_i,
    input wire logic [exu_pkg::XLEN-1:0] int_addr_i,
    input wire logic                     reg_we_o,
    input wire logic                     csr_we_o,
    input wire logic                     jump_flag_o,
    input wire logic [exu_pkg::XLEN-1:0] jump_addr_o
);

    mem_we_has_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_we_o |-> mem_req_o)
        else $error("memory write without a request");

    // trap redirect one cycle after the interrupt
    int_redirect: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        int_assert_i |=> !reg_we_o && !csr_we_o && jump_flag_o &&
                         jump_addr_o == $past(int_addr_i))
        else $error("interrupt not taken on the following cycle");

    reset_quiet: assert property (@(posedge clk_i)
        !arst_n_i |-> !reg_we_o && !csr_we_o && !jump_flag_o)
        else $error("control output active during reset");

endmodule

bind exu_top exu_checker u_checker (.*);

`default_nettype wire

// File: sim/tb_exu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_exu;

    localparam int XLEN         = exu_pkg::XLEN;
    localparam int NUM_INSTS    = 2000;
    localparam int RESET_CYCLES = 5;
    localparam int CLK_PERIOD   = 20;

    logic                           clk_i;
    logic                           arst_n_i;
    logic [XLEN-1:0]                inst_i, op1_i, op2_i, op1_jump_i, op2_jump_i;
    logic [XLEN-1:0]                reg1_r_data_i, reg2_r_data_i, csr_r_data_i, mem_r_data_i;
    logic [XLEN-1:0]                int_addr_i;
    logic [exu_pkg::CSR_ADDR_W-1:0] csr_w_addr_i;
    logic [exu_pkg::REG_ADDR_W-1:0] reg_w_addr_i;
    logic                           reg_we_i, csr_we_i, int_assert_i;
    logic [XLEN-1:0]                mem_addr_o, mem_w_data_o, reg_w_data_o, csr_w_data_o;
    logic [XLEN-1:0]                jump_addr_o;
    logic [exu_pkg::CSR_ADDR_W-1:0] csr_w_addr_o;
    logic [exu_pkg::REG_ADDR_W-1:0] reg_w_addr_o;
    logic                           mem_we_o, mem_req_o, reg_we_o, csr_we_o, jump_flag_o;

    // model outputs
    logic [XLEN-1:0]                exp_mem_addr, exp_mem_w_data, exp_reg_w_data;
    logic [XLEN-1:0]                exp_csr_w_data, exp_jump_addr;
    logic [exu_pkg::CSR_ADDR_W-1:0] exp_csr_w_addr;
    logic [exu_pkg::REG_ADDR_W-1:0] exp_reg_w_addr;
    logic                           exp_mem_req, exp_mem_we, exp_reg_we, exp_csr_we;
    logic                           exp_jump_flag;

    int mem_errs   = 0;
    int stage_errs = 0;

    logic [6:0] opcodes [12] = '{exu_pkg::OPC_TYPE_I, exu_pkg::OPC_TYPE_R, exu_pkg::OPC_TYPE_L,
                                 exu_pkg::OPC_TYPE_S, exu_pkg::OPC_TYPE_B, exu_pkg::OPC_JAL,
                                 exu_pkg::OPC_JALR, exu_pkg::OPC_LUI, exu_pkg::OPC_AUIPC,
                                 exu_pkg::OPC_FENCE, exu_pkg::OPC_CSR, exu_pkg::OPC_NOP};

    exu_top dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic logic [XLEN-1:0] alu_value(input logic [2:0] f3, input logic alt,
                                                  input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            exu_pkg::F3_ADD_SUB: return alt ? a - b : a + b;
            exu_pkg::F3_SLL:     return a << sh;
            exu_pkg::F3_SLT:     return {31'b0, $signed(a) < $signed(b)};
            exu_pkg::F3_SLTU:    return {31'b0, a < b};
            exu_pkg::F3_XOR:     return a ^ b;
            exu_pkg::F3_SR: begin
                if (alt && a[XLEN-1]) return (a >> sh) | ~({XLEN{1'b1}} >> sh); // fill sign
                return a >> sh;
            end
            exu_pkg::F3_OR:      return a | b;
            default:             return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [XLEN-1:0] a,
                                          input logic [XLEN-1:0] b);
        case (f3)
            exu_pkg::F3_BEQ:  return a == b;
            exu_pkg::F3_BNE:  return a != b;
            exu_pkg::F3_BLT:  return $signed(a) < $signed(b);
            exu_pkg::F3_BGE:  return $signed(a) >= $signed(b);
            exu_pkg::F3_BLTU: return a < b;
            exu_pkg::F3_BGEU: return a >= b;
            default:          return 1'b0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] load_value(input logic [2:0] f3, input logic [1:0] lane,
                                                   input logic [XLEN-1:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        case (lane)
            2'd0:    b = word[7:0];
            2'd1:    b = word[15:8];
            2'd2:    b = word[23:16];
            default: b = word[31:24];
        endcase
        h = (lane == 2'd0) ? word[15:0] : word[31:16];
        case (f3)
            exu_pkg::F3_LB:  return {{24{b[7]}}, b};
            exu_pkg::F3_LH:  return {{16{h[15]}}, h};
            exu_pkg::F3_LW:  return word;
            exu_pkg::F3_LBU: return {24'b0, b};
            exu_pkg::F3_LHU: return {16'b0, h};
            default:         return '0;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] store_word(input logic [2:0] f3, input logic [1:0] lane,
                                                   input logic [XLEN-1:0] old,
                                                   input logic [XLEN-1:0] src);
        logic [XLEN-1:0] merged;
        merged = old;
        case (f3)
            exu_pkg::F3_SB: begin
                case (lane)
                    2'd0:    merged[7:0]   = src[7:0];
                    2'd1:    merged[15:8]  = src[7:0];
                    2'd2:    merged[23:16] = src[7:0];
                    default: merged[31:24] = src[7:0];
                endcase
            end
            exu_pkg::F3_SH: begin
                if (lane == 2'd0) merged[15:0] = src[15:0];
                else merged[31:16] = src[15:0];
            end
            exu_pkg::F3_SW: merged = src;
            default:        merged = '0;
        endcase
        return merged;
    endfunction

    task automatic predict();
        logic [6:0]      opcode;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] csr_src;
        logic [XLEN-1:0] result;
        logic            jump;
        logic            is_mem;
        opcode         = inst_i[6:0];
        f3             = inst_i[14:12];
        f7             = inst_i[31:25];
        addr           = op1_i + op2_i;
        result         = '0;
        jump           = 1'b0;
        exp_csr_w_data = '0;
        exp_mem_w_data = '0;
        is_mem = (opcode == exu_pkg::OPC_TYPE_L) || (opcode == exu_pkg::OPC_TYPE_S);
        case (opcode)
            exu_pkg::OPC_TYPE_I:
                result = alu_value(f3, inst_i[30] && f3 == exu_pkg::F3_SR, op1_i, op2_i);
            exu_pkg::OPC_TYPE_R: begin
                if (f7 == 7'h00 || f7 == 7'h20) begin // mul/div decodes as nothing
                    result = alu_value(f3, inst_i[30] && (f3 == exu_pkg::F3_ADD_SUB ||
                                       f3 == exu_pkg::F3_SR), op1_i, op2_i);
                end
            end
            exu_pkg::OPC_TYPE_B: jump = branch_taken(f3, op1_i, op2_i);
            exu_pkg::OPC_JAL, exu_pkg::OPC_JALR: begin
                result = op1_i + op2_i;
                jump   = 1'b1;
            end
            exu_pkg::OPC_LUI, exu_pkg::OPC_AUIPC: result = op1_i + op2_i;
            exu_pkg::OPC_FENCE:  jump = 1'b1;
            exu_pkg::OPC_TYPE_L: result = load_value(f3, addr[1:0], mem_r_data_i);
            exu_pkg::OPC_TYPE_S:
                exp_mem_w_data = store_word(f3, addr[1:0], mem_r_data_i, reg2_r_data_i);
            exu_pkg::OPC_CSR: begin
                csr_src = f3[2] ? {27'b0, inst_i[19:15]} : reg1_r_data_i;
                case (f3[1:0])
                    2'b01:   exp_csr_w_data = csr_src;
                    2'b10:   exp_csr_w_data = csr_r_data_i | csr_src;
                    2'b11:   exp_csr_w_data = csr_r_data_i & ~csr_src;
                    default: ;
                endcase
                if (f3[1:0] != 2'b00) result = csr_r_data_i;
            end
            default: ;
        endcase
        exp_mem_req    = is_mem && !int_assert_i;
        exp_mem_we     = (opcode == exu_pkg::OPC_TYPE_S) && !int_assert_i;
        exp_mem_addr   = is_mem ? addr : '0;
        exp_reg_w_data = result;
        exp_reg_we     = reg_we_i && !int_assert_i;
        exp_reg_w_addr = reg_w_addr_i;
        exp_csr_we     = csr_we_i && !int_assert_i;
        exp_csr_w_addr = csr_w_addr_i;
        exp_jump_flag  = jump || int_assert_i;
        exp_jump_addr  = int_assert_i ? int_addr_i : (jump ? op1_jump_i + op2_jump_i : '0);
    endtask

    //////////////////////////////
    // stimulus and checks
    //////////////////////////////
    task automatic drive_idle();
        {op1_i, op2_i, op1_jump_i, op2_jump_i, reg1_r_data_i, reg2_r_data_i} = '0;
        {csr_r_data_i, mem_r_data_i, int_addr_i, csr_w_addr_i, reg_w_addr_i} = '0;
        {reg_we_i, csr_we_i, int_assert_i} = '0;
        inst_i = {25'b0, exu_pkg::OPC_NOP};
    endtask

    task automatic drive_random();
        logic [31:0] word;
        logic [6:0]  funct7;
        logic [3:0]  sel;
        word   = $urandom;
        sel    = 4'($urandom % 12);
        funct7 = word[31:25];
        if (opcodes[sel] == exu_pkg::OPC_TYPE_R) begin
            funct7 = ($urandom % 6 == 0) ? 7'b0000001 : {1'b0, word[30], 5'b0};
        end
        inst_i        = {funct7, word[24:7], opcodes[sel]};
        op1_i         = $urandom;
        op2_i         = ($urandom % 4 == 0) ? op1_i : $urandom; // equal operands now and then
        op1_jump_i    = $urandom;
        op2_jump_i    = $urandom;
        reg1_r_data_i = $urandom;
        reg2_r_data_i = $urandom;
        csr_r_data_i  = $urandom;
        mem_r_data_i  = $urandom;
        csr_w_addr_i  = $urandom;
        int_addr_i    = $urandom;
        reg_w_addr_i  = 5'($urandom);
        reg_we_i      = 1'($urandom);
        csr_we_i      = 1'($urandom);
        int_assert_i  = ($urandom % 100) < 5;
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual, input bit comb);
        assert (actual === expected) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
            if (comb) mem_errs++;
            else stage_errs++;
        end
    endtask

    task automatic check_memory();
        check_value("mem_req_o", 32'(exp_mem_req), 32'(mem_req_o), 1'b1);
        check_value("mem_we_o", 32'(exp_mem_we), 32'(mem_we_o), 1'b1);
        check_value("mem_addr_o", exp_mem_addr, mem_addr_o, 1'b1);
        check_value("mem_w_data_o", exp_mem_w_data, mem_w_data_o, 1'b1);
    endtask

    task automatic check_stage();
        check_value("reg_w_data_o", exp_reg_w_data, reg_w_data_o, 1'b0);
        check_value("reg_we_o", 32'(exp_reg_we), 32'(reg_we_o), 1'b0);
        check_value("reg_w_addr_o", 32'(exp_reg_w_addr), 32'(reg_w_addr_o), 1'b0);
        check_value("csr_w_data_o", exp_csr_w_data, csr_w_data_o, 1'b0);
        check_value("csr_we_o", 32'(exp_csr_we), 32'(csr_we_o), 1'b0);
        check_value("csr_w_addr_o", exp_csr_w_addr, csr_w_addr_o, 1'b0);
        check_value("jump_flag_o", 32'(exp_jump_flag), 32'(jump_flag_o), 1'b0);
        check_value("jump_addr_o", exp_jump_addr, jump_addr_o, 1'b0);
    endtask

    task automatic clear_expected();
        {exp_mem_addr, exp_mem_w_data, exp_reg_w_data, exp_csr_w_data, exp_jump_addr} = '0;
        {exp_csr_w_addr, exp_reg_w_addr} = '0;
        {exp_mem_req, exp_mem_we, exp_reg_we, exp_csr_we, exp_jump_flag} = '0;
    endtask

    initial begin
        void'($urandom(32'h233e));
        drive_idle();
        arst_n_i = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        arst_n_i = 1'b1;
        clear_expected();
        check_stage();
        @(negedge clk_i);
        check_stage(); // idle cycle retires nothing

        for (int n = 0; n < NUM_INSTS; n++) begin
            drive_random();
            predict();
            #1;
            check_memory();
            @(negedge clk_i);
            check_stage();
        end

        $display("errors: memory %0d, stage %0d", mem_errs, stage_errs);
        if (mem_errs + stage_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((NUM_INSTS + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("timeout: the instruction loop did not finish in time");
        $display("errors: memory %0d, stage %0d", mem_errs, stage_errs);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
logic/exu_pkg.sv
logic/exu_decode.sv
logic/exu_alu.sv
logic/exu_branch.sv
logic/exu_lsu.sv
logic/exu_csr.sv
logic/exu_retire.sv
logic/exu_top.sv
sim/exu_checker.sv
sim/tb_exu.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -f verilog.f --top-module tb_exu > sim.log 2>&1 \
    && ./obj_dir/Vtb_exu >> sim.log 2>&1 \
    || echo "Some tests failed" >> sim.log

cat sim.log
grep -q "Some tests failed" sim.log && echo "FAIL" && exit 1
echo "PASS"
